// File: common/mem_map_pkg.sv
// ############################
// Data memory address map
// RAM window, I/O register addresses and the decoded region type
// ############################

package mem_map_pkg;

    // ############################
    // Address map
    // ############################

    // LED register, one full word at an odd byte address
    localparam logic [31:0] LED_ADDR  = 32'h4000_0003;

    // Display register, digit enables and segments
    localparam logic [31:0] DISP_ADDR = 32'h4000_0100;

    // Default RAM depth in 32-bit words
    localparam int unsigned MEM_WORDS_DEFAULT = 512;

    // ############################
    // Decoded region
    // ############################

    // Target of a single access
    // RAM wins over I/O when both would match
    typedef enum logic [1:0] {
        REGION_RAM  = 2'd0,  // Word index below MEM_WORDS
        REGION_IO   = 2'd1,  // LED_ADDR or DISP_ADDR exactly
        REGION_NONE = 2'd2   // Unmapped, writes dropped, reads zero
    } region_e;

endpackage : mem_map_pkg

// File: common/io_pkg.sv
// ############################
// Output register definitions
// Field widths, bit positions and register index
// ############################

package io_pkg;

    // Output widths
    localparam int unsigned LED_W = 8;  // Board LEDs
    localparam int unsigned AN_W  = 4;  // Digit enables
    localparam int unsigned SEG_W = 8;  // Segment pattern incl. dot

    // Display word layout, same for write and readback
    localparam int unsigned SEG_LSB = 0;  // Bits 7..0
    localparam int unsigned AN_LSB  = 8;  // Bits 11..8

    // Register select on the I/O port
    typedef enum logic {
        IO_LED  = 1'b0,
        IO_DISP = 1'b1
    } io_reg_e;

endpackage : io_pkg

// File: common/ram_port_if.sv
// ############################
// Decoder to data RAM port
// Word index, write data and enable, read data back
// ############################

interface ram_port_if #(
    parameter int unsigned MEM_WORDS = mem_map_pkg::MEM_WORDS_DEFAULT
);

    // Index width from depth, at least one bit
    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [IDX_W-1:0] idx;    // Word index
    logic [31:0]      wdata;  // Store data
    logic             we;     // Write at next rising edge
    logic [31:0]      rdata;  // Combinational read at idx

    // Decoder side
    modport ctrl (
        output idx,
        output wdata,
        output we,
        input  rdata
    );

    // RAM side
    modport mem (
        input  idx,
        input  wdata,
        input  we,
        output rdata
    );

endinterface : ram_port_if

// File: common/io_port_if.sv
// ############################
// Decoder to I/O register port
// Register select, write data and enable, readback
// ############################

interface io_port_if;

    io_pkg::io_reg_e idx;    // Which output register
    logic [31:0]     wdata;  // Store data, fields per io_pkg
    logic            we;     // Write at next rising edge
    logic [31:0]     rdata;  // Readback of selected register

    // Decoder side
    modport ctrl (
        output idx,
        output wdata,
        output we,
        input  rdata
    );

    // Register block side
    modport regs (
        input  idx,
        input  wdata,
        input  we,
        output rdata
    );

endinterface : io_port_if

// File: rtl/dmem_decode.sv
// ############################
// Data memory address decoder
// Classifies each access, steers write strobes
// and selects the read data by region
// ############################

module dmem_decode #(
    parameter int unsigned MEM_WORDS = mem_map_pkg::MEM_WORDS_DEFAULT
) (
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        read,
    input  logic        write,
    output logic [31:0] rdata,
    ram_port_if.ctrl    ram,
    io_port_if.ctrl     io
);

    // RAM index width, same rule as ram_port_if
    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // Word count as a 32-bit compare limit
    localparam logic [31:0] RAM_LIMIT = 32'(MEM_WORDS);

    mem_map_pkg::region_e region;  // Decoded once, used everywhere below
    logic                 is_disp; // Exact match on display address

    // ############################
    // Region decode
    // ############################

    assign is_disp = (addr == mem_map_pkg::DISP_ADDR);

    always_comb begin
        if ({2'b00, addr[31:2]} < RAM_LIMIT) begin
            region = mem_map_pkg::REGION_RAM;   // Byte offset ignored
        end else if ((addr == mem_map_pkg::LED_ADDR) || is_disp) begin
            region = mem_map_pkg::REGION_IO;
        end else begin
            region = mem_map_pkg::REGION_NONE;
        end
    end

    // ############################
    // Write steering
    // ############################

    // RAM side
    assign ram.idx   = addr[IDX_W+1:2];
    assign ram.wdata = wdata;
    assign ram.we    = write && (region == mem_map_pkg::REGION_RAM);

    // I/O side, select only meaningful inside the I/O region
    always_comb begin
        io.idx = io_pkg::IO_LED;
        if (region == mem_map_pkg::REGION_IO && is_disp) begin
            io.idx = io_pkg::IO_DISP;
        end
    end

    assign io.wdata = wdata;
    assign io.we    = write && (region == mem_map_pkg::REGION_IO);

    // ############################
    // Read mux
    // ############################

    always_comb begin
        rdata = '0;  // Idle bus and unmapped reads
        if (read) begin
            case (region)
                mem_map_pkg::REGION_RAM: rdata = ram.rdata;
                mem_map_pkg::REGION_IO:  rdata = io.rdata;
                default:                 rdata = '0;
            endcase
        end
    end

endmodule : dmem_decode

// File: rtl/data_ram.sv
// ############################
// Data RAM
// Word array, write on rising edge, asynchronous read
// ############################

module data_ram #(
    parameter int unsigned MEM_WORDS = mem_map_pkg::MEM_WORDS_DEFAULT
) (
    input  logic     clk,
    ram_port_if.mem  port
);

    // ############################
    // Storage
    // ############################

    // Contents undefined until written
    logic [31:0] mem [MEM_WORDS];

    // ############################
    // Write port
    // ############################

    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.idx] <= port.wdata;  // Full word, no byte lanes
        end
    end

    // ############################
    // Read port
    // ############################

    // Same cycle as the index, old data during a write
    assign port.rdata = mem[port.idx];

endmodule : data_ram

// File: rtl/io_regs.sv
// ############################
// Memory-mapped output registers
// LED and display registers with readback
// ############################

module io_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    io_port_if.regs                  port,
    output logic [io_pkg::LED_W-1:0] leds,
    output logic [io_pkg::AN_W-1:0]  an,
    output logic [io_pkg::SEG_W-1:0] seg
);

    // ############################
    // Register writes
    // ############################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;  // Board dark after reset
            an   <= '0;
            seg  <= '0;
        end else if (port.we) begin
            case (port.idx)
                io_pkg::IO_LED: begin
                    leds <= port.wdata[io_pkg::LED_W-1:0];
                end
                io_pkg::IO_DISP: begin
                    // Both display fields from one word
                    seg <= port.wdata[io_pkg::SEG_LSB +: io_pkg::SEG_W];
                    an  <= port.wdata[io_pkg::AN_LSB +: io_pkg::AN_W];
                end
                default: ;
            endcase
        end
    end

    // ############################
    // Readback
    // ############################

    always_comb begin
        port.rdata = '0;  // Upper bits stay zero
        case (port.idx)
            io_pkg::IO_LED: begin
                port.rdata[io_pkg::LED_W-1:0] = leds;
            end
            io_pkg::IO_DISP: begin
                port.rdata[io_pkg::SEG_LSB +: io_pkg::SEG_W] = seg;
                port.rdata[io_pkg::AN_LSB +: io_pkg::AN_W]   = an;
            end
            default: ;
        endcase
    end

endmodule : io_regs

// File: rtl/dmem_top.sv
// ############################
// Data memory subsystem top
// Core load/store bus in, LED and display outputs
// ############################

module dmem_top #(
    parameter int unsigned MEM_WORDS = mem_map_pkg::MEM_WORDS_DEFAULT
) (
    input  logic                     clk,
    input  logic                     arst_n,
    // Core bus
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    input  logic                     read,
    input  logic                     write,
    output logic [31:0]              rdata,
    // Board outputs
    output logic [io_pkg::LED_W-1:0] leds,
    output logic [io_pkg::AN_W-1:0]  an,
    output logic [io_pkg::SEG_W-1:0] seg
);

    // ############################
    // Internal ports
    // ############################

    ram_port_if #(.MEM_WORDS(MEM_WORDS)) ram_bus ();  // Decoder to RAM
    io_port_if                           io_bus ();   // Decoder to I/O

    // ############################
    // Blocks
    // ############################

    // Single point of address decode
    dmem_decode #(
        .MEM_WORDS (MEM_WORDS)
    ) u_decode (
        .addr  (addr),
        .wdata (wdata),
        .read  (read),
        .write (write),
        .rdata (rdata),
        .ram   (ram_bus),
        .io    (io_bus)
    );

    data_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk  (clk),
        .port (ram_bus)
    );

    // Only block with reset
    io_regs u_io (
        .clk    (clk),
        .arst_n (arst_n),
        .port   (io_bus),
        .leds   (leds),
        .an     (an),
        .seg    (seg)
    );

endmodule : dmem_top

// File: verif/tb_dmem.sv
// ##############################
// Data memory testbench
// Region model, bus stimulus, assertions
// ##############################

module tb_dmem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned WORDS    = mem_map_pkg::MEM_WORDS_DEFAULT;
    localparam int unsigned SEED     = 32'h0f92_d8c3;

    logic                     clk;
    logic                     arst_n;
    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic                     read;
    logic                     write;
    logic [31:0]              rdata;
    logic [io_pkg::LED_W-1:0] leds;
    logic [io_pkg::AN_W-1:0]  an;
    logic [io_pkg::SEG_W-1:0] seg;

    // Reference model state
    logic [31:0] ram_m [int unsigned];  // Written words only
    logic [7:0]  leds_m;
    logic [3:0]  an_m;
    logic [7:0]  seg_m;

    int errors;
    int err_base;   // Error count at test start
    int test_pass;
    int test_fail;

    dmem_top DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr),
        .wdata  (wdata),
        .read   (read),
        .write  (write),
        .rdata  (rdata),
        .leds   (leds),
        .an     (an),
        .seg    (seg)
    );

    always #10 clk = ~clk;

    // ##############################
    // Concurrent checks
    // ##############################

    // Idle bus reads zero
    read_idle_zero: assert property (@(negedge clk) !read |-> rdata == 32'd0)
        else begin
            $display("Mismatch at %0t: rdata expected 0x00000000, got 0x%08h",
                     $time, $sampled(rdata));
            errors++;
        end

    // Board dark during reset
    reset_dark: assert property (@(negedge clk) !arst_n |-> (leds == '0 && an == '0 && seg == '0))
        else begin
            $display("Mismatch at %0t: leds/an/seg expected 0x00000, got 0x%05h",
                     $time, {$sampled(leds), $sampled(an), $sampled(seg)});
            errors++;
        end

    // ##############################
    // Model
    // ##############################

    function automatic mem_map_pkg::region_e region_of(input logic [31:0] a);
        if ({2'b00, a[31:2]} < WORDS) begin
            return mem_map_pkg::REGION_RAM;  // Offset ignored
        end
        if (a == mem_map_pkg::LED_ADDR || a == mem_map_pkg::DISP_ADDR) begin
            return mem_map_pkg::REGION_IO;
        end
        return mem_map_pkg::REGION_NONE;
    endfunction

    function automatic void model_write(input logic [31:0] a, input logic [31:0] d);
        case (region_of(a))
            mem_map_pkg::REGION_RAM: ram_m[{2'b00, a[31:2]}] = d;
            mem_map_pkg::REGION_IO: begin
                if (a == mem_map_pkg::LED_ADDR) begin
                    leds_m = d[7:0];
                end else begin
                    seg_m = d[7:0];   // Segments low byte
                    an_m  = d[11:8];  // Digit enables above
                end
            end
            default: ;  // Unmapped write dropped
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        logic [31:0] v;
        v = 32'd0;
        case (region_of(a))
            mem_map_pkg::REGION_RAM: begin
                if (ram_m.exists({2'b00, a[31:2]})) begin
                    v = ram_m[{2'b00, a[31:2]}];
                end
            end
            mem_map_pkg::REGION_IO: begin
                v = (a == mem_map_pkg::LED_ADDR) ? {24'd0, leds_m} : {20'd0, an_m, seg_m};
            end
            default: ;
        endcase
        return v;
    endfunction

    // ##############################
    // Checks and bus tasks
    // ##############################

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_value("leds", {24'd0, leds_m}, 32'(leds));
        check_value("an", {28'd0, an_m}, 32'(an));
        check_value("seg", {24'd0, seg_m}, 32'(seg));
    endtask

    // One store, model follows at the edge
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        write = 1'b1;
        read  = 1'b0;
        @(posedge clk);
        model_write(a, d);
        @(negedge clk);
        write = 1'b0;
    endtask

    // One load, sampled mid cycle
    task automatic bus_read_check(input logic [31:0] a);
        @(negedge clk);
        addr  = a;
        read  = 1'b1;
        write = 1'b0;
        #5;
        check_value($sformatf("rdata @0x%08h", a), model_read(a), rdata);
        @(negedge clk);
        read = 1'b0;
    endtask

    task automatic verify_ram();
        foreach (ram_m[k]) begin
            bus_read_check(k << 2);
        end
    endtask

    task automatic start_test();
        err_base = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            test_pass++;
            $display("Test %s: ok", name);
        end else begin
            test_fail++;
            $display("Test %s: FAILED with %0d errors", name, errors - err_base);
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] old_d;
        int unsigned idx;
        logic [1:0]  off;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        clk    = 1'b0;
        arst_n = 1'b0;
        addr   = 32'd0;
        wdata  = 32'd0;
        read   = 1'b0;
        write  = 1'b0;
        leds_m = 8'd0;
        an_m   = 4'd0;
        seg_m  = 8'd0;
        errors = 0;
        test_pass = 0;
        test_fail = 0;

        // Reset, then idle reads at mapped and random addresses
        start_test();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #5;
        check_outputs();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            addr = (i == 0) ? mem_map_pkg::LED_ADDR : (i == 1) ? mem_map_pkg::DISP_ADDR : $urandom;
            #5;
            check_value("rdata", 32'd0, rdata);
        end
        finish_test("reset and idle bus");

        start_test();
        for (int i = 0; i < 16; i++) begin
            idx = $urandom_range(WORDS - 1, 0);
            off = 2'($urandom);
            bus_write({idx[29:0], off}, $urandom);
            bus_read_check({idx[29:0], off ^ 2'($urandom_range(3, 1))});  // Other offset
        end
        verify_ram();
        finish_test("RAM write and readback");

        start_test();
        for (int i = 0; i < 4; i++) begin
            d = $urandom;
            bus_write(mem_map_pkg::LED_ADDR, d);
            check_outputs();  // Already updated by the write edge
            check_value("leds", {24'd0, d[7:0]}, 32'(leds));
            bus_read_check(mem_map_pkg::LED_ADDR);
        end
        finish_test("LED register");

        start_test();
        for (int i = 0; i < 4; i++) begin
            d = $urandom;
            bus_write(mem_map_pkg::DISP_ADDR, d);
            check_outputs();
            check_value("seg", {24'd0, d[7:0]}, 32'(seg));
            check_value("an", {28'd0, d[11:8]}, 32'(an));
            bus_read_check(mem_map_pkg::DISP_ADDR);
        end
        finish_test("display register");

        // Near misses around the I/O words and above the RAM
        start_test();
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: a = WORDS << 2;
                1: a = mem_map_pkg::LED_ADDR - 32'd1;
                2: a = mem_map_pkg::LED_ADDR + 32'd4;
                3: a = mem_map_pkg::DISP_ADDR + 32'd1;
                4: a = 32'hFFFF_FFFC;
                default: a = (WORDS << 2) + ($urandom % 32'h3FFF_0000);
            endcase
            bus_write(a, $urandom);
            bus_read_check(a);
        end
        check_outputs();
        verify_ram();
        finish_test("unmapped addresses");

        start_test();
        bus_write(mem_map_pkg::LED_ADDR, $urandom);
        bus_write(mem_map_pkg::DISP_ADDR, $urandom);
        check_outputs();
        verify_ram();
        idx = $urandom_range(WORDS - 1, 0);
        bus_write({idx[29:0], 2'b00}, $urandom);
        check_outputs();
        // Load and store together on one word
        a     = {idx[29:0], 2'b00};
        old_d = ram_m[idx];
        d     = ~old_d;
        @(negedge clk);
        addr  = a;
        wdata = d;
        read  = 1'b1;
        write = 1'b1;
        #5;
        check_value("rdata before edge", old_d, rdata);
        @(posedge clk);
        model_write(a, d);
        #5;
        check_value("rdata after edge", d, rdata);
        @(negedge clk);
        read  = 1'b0;
        write = 1'b0;
        verify_ram();
        check_outputs();
        finish_test("isolation and read during write");

        // Reset with the board lit, RAM keeps its words
        start_test();
        bus_write(mem_map_pkg::LED_ADDR, 32'h0000_005A);
        bus_write(mem_map_pkg::DISP_ADDR, 32'h0000_0A3C);
        check_outputs();
        @(negedge clk);
        arst_n = 1'b0;
        leds_m = 8'd0;
        an_m   = 4'd0;
        seg_m  = 8'd0;
        #1;
        check_outputs();  // Cleared before the next rising edge
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        verify_ram();
        check_outputs();
        finish_test("reset with outputs set");

        $display("Tests: %0d ok, %0d failing, %0d errors", test_pass, test_fail, errors);
        if (errors == 0 && test_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_dmem

// File: flist.f
common/mem_map_pkg.sv
common/io_pkg.sv
common/ram_port_if.sv
common/io_port_if.sv
rtl/dmem_decode.sv
rtl/data_ram.sv
rtl/io_regs.sv
rtl/dmem_top.sv
verif/tb_dmem.sv

// File: run.sh
#!/bin/sh
# Build the data memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dmem -f flist.f -o tb_dmem \
    || { echo "Build failed"; exit 1; }

out="$(./obj_dir/tb_dmem)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Simulation passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
